// File: hw/eth_pkg.sv
package eth_pkg;

	// --------------------
	// basic types

	typedef logic [7:0]  byte_t;   // one GMII octet
	typedef logic [31:0] crc_t;    // CRC-32 register

	// --------------------
	// frame constants

	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE      = 8'hD5;
	localparam int    PREAMBLE_LEN  = 7;     // octets before the delimiter
	localparam int    IPG_CYCLES    = 12;    // idle cycles between frames
	localparam int    FCS_BYTES     = 4;

	// --------------------
	// CRC-32 constants

	localparam crc_t CRC_POLY    = 32'hEDB88320;  // reflected 802.3 polynomial
	localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
	// register value once a good frame has been run through including its FCS
	localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

	// one byte into the register, bit 0 of the byte goes first on the wire,
	// so the register shifts right and the polynomial is bit reversed
	function automatic crc_t next_crc32(crc_t crc, byte_t data);
		crc_t c;
		c = crc ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	// the FCS on the wire is ~crc, low byte first, which is the plain zlib CRC-32
	// of the payload; the receiver just keeps updating and compares to the residue

endpackage

// File: hw/ring_wr_if.sv
`timescale 1ns/1ns

interface ring_wr_if;
	import eth_pkg::*;

	byte_t data;
	logic  valid;
	logic  ready;    // low when no free slot or open slot full
	logic  commit;   // closes the open packet
	logic  abort;    // drops the open packet

	modport producer (
		output data, valid, commit, abort,
		input  ready
	);

	modport ring (
		input  data, valid, commit, abort,
		output ready
	);

endinterface

// File: hw/ring_rd_if.sv
`timescale 1ns/1ns

interface ring_rd_if;
	import eth_pkg::*;

	byte_t data;
	logic  valid;    // only while a committed packet replays
	logic  last;     // final byte of the packet
	logic  ready;

	modport ring (
		output data, valid, last,
		input  ready
	);

	modport consumer (
		input  data, valid, last,
		output ready
	);

endinterface

// File: hw/frame_ring.sv
`timescale 1ns/1ns

module frame_ring #(
	parameter int SLOT_COUNT = 4,
	parameter int SLOT_BYTES = 256
) (
	input logic     clock,
	input logic     reset,
	ring_wr_if.ring wr,
	ring_rd_if.ring rd
);
	import eth_pkg::*;

	localparam int SLOT_W = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;
	localparam int ADDR_W = (SLOT_BYTES > 1) ? $clog2(SLOT_BYTES) : 1;
	localparam int LEN_W  = $clog2(SLOT_BYTES + 1);
	localparam int CNT_W  = $clog2(SLOT_COUNT + 1);

	byte_t            mem [SLOT_COUNT][SLOT_BYTES];
	logic [LEN_W-1:0] lens [SLOT_COUNT];

	logic [SLOT_W-1:0] wr_slot;          // open slot
	logic [LEN_W-1:0]  wr_addr;          // bytes in the open slot
	logic [SLOT_W-1:0] rd_slot;          // slot being replayed
	logic [LEN_W-1:0]  rd_addr;          // next byte to fetch
	logic [CNT_W-1:0]  used;             // committed slots not yet freed
	logic [CNT_W-1:0]  queued;           // committed slots not yet fully fetched

	logic              accept;
	logic              commit_fire;
	logic              store_len;
	logic [LEN_W-1:0]  wr_len;
	logic [LEN_W-1:0]  wr_addr_next;
	logic [SLOT_W-1:0] wr_slot_next;
	logic [CNT_W-1:0]  used_next;
	logic [CNT_W-1:0]  queued_next;
	logic              issue;            // fetch a byte into the output register
	logic              issue_last;

	function automatic logic [SLOT_W-1:0] next_slot(logic [SLOT_W-1:0] slot);
		return (slot == SLOT_W'(SLOT_COUNT - 1)) ? '0 : slot + 1'b1;
	endfunction

	// --------------------
	// next state

	always_comb begin
		accept       = wr.valid && wr.ready;
		commit_fire  = wr.commit && (accept || !wr.valid);  // with a byte or alone
		wr_len       = wr_addr + LEN_W'(accept);
		store_len    = commit_fire && !wr.abort && (wr_len != '0);  // empty packets vanish
		wr_addr_next = wr_len;
		wr_slot_next = wr_slot;
		used_next    = used;
		queued_next  = queued;

		if (wr.abort || commit_fire) begin
			wr_addr_next = '0;
		end
		if (store_len) begin
			wr_slot_next = next_slot(wr_slot);
			used_next    = used + 1'b1;
			queued_next  = queued + 1'b1;
		end

		issue      = (!rd.valid || rd.ready) && (queued != '0);
		issue_last = issue && (rd_addr + 1'b1 == lens[rd_slot]);
		if (issue_last) begin
			queued_next = queued_next - 1'b1;
		end
		if (rd.valid && rd.ready && rd.last) begin
			used_next = used_next - 1'b1;  // slot free once its last byte left
		end
	end

	// --------------------
	// control registers

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_slot  <= '0;
			wr_addr  <= '0;
			rd_slot  <= '0;
			rd_addr  <= '0;
			used     <= '0;
			queued   <= '0;
			wr.ready <= 1'b0;
			rd.valid <= 1'b0;
			rd.last  <= 1'b0;
		end else begin
			wr_slot  <= wr_slot_next;
			wr_addr  <= wr_addr_next;
			used     <= used_next;
			queued   <= queued_next;
			wr.ready <= (used_next != CNT_W'(SLOT_COUNT)) &&
				(wr_addr_next != LEN_W'(SLOT_BYTES));

			if (issue) begin
				if (issue_last) begin
					rd_slot <= next_slot(rd_slot);
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
			if (!rd.valid || rd.ready) begin  // output stage empty or draining
				rd.valid <= issue;
				rd.last  <= issue_last;
			end
		end
	end

	// --------------------
	// storage

	always_ff @(posedge clock) begin
		if (accept) begin
			mem[wr_slot][wr_addr[ADDR_W-1:0]] <= wr.data;
		end
		if (store_len) begin
			lens[wr_slot] <= wr_len;
		end
		if (issue) begin
			rd.data <= mem[rd_slot][rd_addr[ADDR_W-1:0]];  // registered read
		end
	end

endmodule

// File: hw/gmii_tx.sv
`timescale 1ns/1ns

module gmii_tx (
	input logic          clock,
	input logic          reset,
	ring_rd_if.consumer  rd,
	output eth_pkg::byte_t gmii_txd,
	output logic         gmii_tx_en
);
	import eth_pkg::*;

	// state names what is on the wire right now
	typedef enum logic [2:0] {
		S_IDLE,
		S_PREAMBLE,
		S_DELIMITER,
		S_PAYLOAD,
		S_CHECK,
		S_GAP
	} state_t;

	state_t     state;
	logic [3:0] count;     // preamble, check and gap counter
	crc_t       crc;
	crc_t       fcs;

	assign fcs = ~crc;

	// payload taken while the delimiter or a payload byte is out
	assign rd.ready = (state == S_DELIMITER) || (state == S_PAYLOAD);

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= S_IDLE;
			count      <= '0;
			gmii_txd   <= '0;
			gmii_tx_en <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					gmii_txd   <= '0;
					gmii_tx_en <= 1'b0;
					if (rd.valid) begin  // a whole packet is committed
						gmii_txd   <= PREAMBLE_BYTE;
						gmii_tx_en <= 1'b1;
						count      <= 4'd1;
						crc        <= CRC_INIT;
						state      <= S_PREAMBLE;
					end
				end
				S_PREAMBLE: begin
					if (count == 4'(PREAMBLE_LEN)) begin
						gmii_txd <= SFD_BYTE;
						state    <= S_DELIMITER;
					end else begin
						gmii_txd <= PREAMBLE_BYTE;
						count    <= count + 1'b1;
					end
				end
				S_DELIMITER, S_PAYLOAD: begin
					if (rd.valid) begin
						gmii_txd <= rd.data;
						crc      <= next_crc32(crc, rd.data);
						state    <= S_PAYLOAD;
						if (rd.last) begin
							count <= '0;
							state <= S_CHECK;
						end
					end
				end
				S_CHECK: begin
					gmii_txd <= fcs[{count[1:0], 3'b000} +: 8];  // low byte first
					if (count == 4'(FCS_BYTES - 1)) begin
						count <= '0;
						state <= S_GAP;
					end else begin
						count <= count + 1'b1;
					end
				end
				S_GAP: begin
					gmii_txd   <= '0;
					gmii_tx_en <= 1'b0;
					if (count == 4'(IPG_CYCLES - 1)) begin
						state <= S_IDLE;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/gmii_rx.sv
`timescale 1ns/1ns

module gmii_rx (
	input logic           clock,
	input logic           reset,
	input eth_pkg::byte_t gmii_rxd,
	input logic           gmii_rx_dv,
	input logic           gmii_rx_er,
	ring_wr_if.producer   wr
);
	import eth_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_PREAMBLE,
		S_DATA,
		S_DISCARD
	} state_t;

	state_t     state;
	logic [3:0] pre_count;             // preamble bytes seen
	crc_t       crc;
	byte_t      delay [FCS_BYTES];     // holds back the last four bytes
	logic [2:0] fill;                  // valid stages in the delay line
	logic       line_full;
	logic       frame_ok;
	logic       write_byte;
	logic       write_lost;            // ring refused a byte

	assign line_full = (fill == 3'(FCS_BYTES));
	assign frame_ok  = line_full && (crc == CRC_RESIDUE);

	// --------------------
	// ring write side

	always_comb begin
		write_byte = (state == S_DATA) && gmii_rx_dv && !gmii_rx_er && line_full;
		write_lost = write_byte && !wr.ready;

		wr.data   = delay[FCS_BYTES-1];  // oldest byte, surely not FCS
		wr.valid  = write_byte;
		wr.commit = (state == S_DATA) && !gmii_rx_dv && frame_ok;
		wr.abort  = 1'b0;
		if (state == S_DATA) begin
			if (gmii_rx_dv) begin
				wr.abort = gmii_rx_er || write_lost;
			end else begin
				wr.abort = !frame_ok;  // bad crc or runt
			end
		end
	end

	// --------------------
	// FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= S_IDLE;
			pre_count <= '0;
			fill      <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (gmii_rx_dv && !gmii_rx_er && gmii_rxd == PREAMBLE_BYTE) begin
						pre_count <= 4'd1;
						state     <= S_PREAMBLE;
					end
				end
				S_PREAMBLE: begin
					if (!gmii_rx_dv || gmii_rx_er) begin
						state <= S_IDLE;
					end else if (gmii_rxd == PREAMBLE_BYTE &&
							pre_count != 4'(PREAMBLE_LEN)) begin
						pre_count <= pre_count + 1'b1;
					end else if (gmii_rxd == SFD_BYTE && pre_count == 4'(PREAMBLE_LEN)) begin
						fill  <= '0;
						state <= S_DATA;
					end else begin
						state <= S_IDLE;  // wrong byte
					end
				end
				S_DATA: begin
					if (!gmii_rx_dv) begin
						state <= S_IDLE;  // commit or abort happens this cycle
					end else if (gmii_rx_er || write_lost) begin
						state <= S_DISCARD;
					end else if (!line_full) begin
						fill <= fill + 1'b1;
					end
				end
				S_DISCARD: begin
					if (!gmii_rx_dv) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// CRC and delay line

	always_ff @(posedge clock) begin
		if (state == S_PREAMBLE) begin
			crc <= CRC_INIT;
		end else if (state == S_DATA && gmii_rx_dv) begin
			crc <= next_crc32(crc, gmii_rxd);
		end

		if (gmii_rx_dv) begin
			delay[0] <= gmii_rxd;
			for (int i = 1; i < FCS_BYTES; i++) begin
				delay[i] <= delay[i-1];
			end
		end
	end

endmodule

// File: hw/eth_mac.sv
`timescale 1ns/1ns

module eth_mac #(
	parameter int SLOT_COUNT = 4,
	parameter int SLOT_BYTES = 256
) (
	input logic            clock,
	input logic            reset,

	// host transmit stream
	input eth_pkg::byte_t  tx_data,
	input logic            tx_valid,
	input logic            tx_last,
	output logic           tx_ready,

	// host receive stream
	output eth_pkg::byte_t rx_data,
	output logic           rx_valid,
	output logic           rx_last,
	input logic            rx_ready,

	// GMII
	output eth_pkg::byte_t gmii_txd,
	output logic           gmii_tx_en,
	input eth_pkg::byte_t  gmii_rxd,
	input logic            gmii_rx_dv,
	input logic            gmii_rx_er
);

	ring_wr_if tx_wr ();
	ring_rd_if tx_rd ();
	ring_wr_if rx_wr ();
	ring_rd_if rx_rd ();

	// --------------------
	// host side

	assign tx_wr.data   = tx_data;
	assign tx_wr.valid  = tx_valid;
	assign tx_wr.commit = tx_last;   // last byte closes the frame
	assign tx_wr.abort  = 1'b0;      // host never cancels
	assign tx_ready     = tx_wr.ready;

	assign rx_data      = rx_rd.data;
	assign rx_valid     = rx_rd.valid;
	assign rx_last      = rx_rd.last;
	assign rx_rd.ready  = rx_ready;

	// --------------------
	// transmit path

	frame_ring #(
		.SLOT_COUNT(SLOT_COUNT),
		.SLOT_BYTES(SLOT_BYTES)
	) i_tx_ring (
		.clock(clock),
		.reset(reset),
		.wr(tx_wr.ring),
		.rd(tx_rd.ring)
	);

	gmii_tx i_gmii_tx (
		.clock(clock),
		.reset(reset),
		.rd(tx_rd.consumer),
		.gmii_txd(gmii_txd),
		.gmii_tx_en(gmii_tx_en)
	);

	// --------------------
	// receive path

	gmii_rx i_gmii_rx (
		.clock(clock),
		.reset(reset),
		.gmii_rxd(gmii_rxd),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er),
		.wr(rx_wr.producer)
	);

	frame_ring #(
		.SLOT_COUNT(SLOT_COUNT),
		.SLOT_BYTES(SLOT_BYTES)
	) i_rx_ring (
		.clock(clock),
		.reset(reset),
		.wr(rx_wr.ring),
		.rd(rx_rd.ring)
	);

endmodule

// File: dv/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef logic [7:0] bytes_t [$];

// --------------------
// reference models

// plain zlib CRC-32 of a payload, already complemented
function automatic logic [31:0] crc32_ref(bytes_t payload);
	logic [31:0] r;
	logic [7:0]  d;
	logic        fb;
	r = 32'hFFFFFFFF;
	foreach (payload[i]) begin
		d = payload[i];
		for (int b = 0; b < 8; b++) begin
			fb = r[0] ^ d[0];   // lsb of the octet first
			r  = {1'b0, r[31:1]};
			d  = d >> 1;
			if (fb) begin
				r = r ^ 32'hEDB88320;
			end
		end
	end
	return ~r;
endfunction

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// octets as they appear on GMII while the enable is high
function automatic bytes_t build_frame(bytes_t payload);
	bytes_t      f;
	logic [31:0] fcs;
	fcs = crc32_ref(payload);
	repeat (7) begin
		f.push_back(8'h55);
	end
	f.push_back(8'hD5);
	foreach (payload[i]) begin
		f.push_back(payload[i]);
	end
	for (int k = 0; k < 4; k++) begin
		f.push_back(fcs[7:0]);   // low byte first
		fcs = fcs >> 8;
	end
	return f;
endfunction

`endif

// File: dv/tb_eth_mac.sv
`timescale 1ns/1ns

module tb_eth_mac;

	localparam int CLOCK_NS = 100;
	// 21 short frames of at most 64 bytes and one of 200, each with framing and gap,
	// at four cycles per byte for the stalled receive stream
	localparam int BUDGET_BYTES = 21 * (64 + 24) + 200 + 24;
	localparam int WATCHDOG_NS  = (BUDGET_BYTES * 4 + 1000) * CLOCK_NS;

	logic       clock;
	logic       reset;
	logic [7:0] tx_data;
	logic       tx_valid;
	logic       tx_last;
	logic       tx_ready;
	logic [7:0] rx_data;
	logic       rx_valid;
	logic       rx_last;
	logic       rx_ready;
	logic [7:0] gmii_txd;
	logic       gmii_tx_en;
	logic [7:0] gmii_rxd;
	logic       gmii_rx_dv;
	logic       gmii_rx_er;

	`include "tb_ref.svh"

	logic [31:0] lfsr_state;       // stimulus random source
	int          ready_mode;       // 0 low, 1 high, 2 random
	int          tx_stalls;        // cycles the host waited on tx_ready
	logic [7:0]  tx_exp [$];       // expected wire bytes
	int          tx_len_exp [$];   // expected tx_en high time per frame
	logic [7:0]  rx_exp [$];
	logic        rx_last_exp [$];

	eth_mac #(
		.SLOT_COUNT(4),
		.SLOT_BYTES(256)
	) i_eth_mac (
		.clock(clock),
		.reset(reset),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.tx_ready(tx_ready),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_last(rx_last),
		.rx_ready(rx_ready),
		.gmii_txd(gmii_txd),
		.gmii_tx_en(gmii_tx_en),
		.gmii_rxd(gmii_rxd),
		.gmii_rx_dv(gmii_rx_dv),
		.gmii_rx_er(gmii_rx_er)
	);

	// --------------------
	// helpers

	task automatic report_error(string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#10;   // inputs change after the edge
	endtask

	function automatic int take_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic bytes_t random_payload(int len);
		bytes_t p;
		for (int i = 0; i < len; i++) begin
			p.push_back(8'(take_bits(8)));
		end
		return p;
	endfunction

	function automatic int random_len();
		return 8 + (take_bits(6) % 57);   // 8 to 64
	endfunction

	task automatic push_frame(bytes_t payload, bit gaps);
		bytes_t frame;
		logic   ready_now;
		frame = build_frame(payload);
		foreach (frame[i]) begin
			tx_exp.push_back(frame[i]);
		end
		tx_len_exp.push_back(frame.size());
		foreach (payload[i]) begin
			if (gaps && take_bits(1) == 1) begin
				tx_valid = 1'b0;
				tx_last  = 1'b0;
				next_cycle();
			end
			tx_data   = payload[i];
			tx_valid  = 1'b1;
			tx_last   = (i == payload.size() - 1);
			ready_now = 1'b0;
			while (!ready_now) begin
				ready_now = tx_ready;   // registered so steady until the next edge
				next_cycle();
				if (!ready_now) begin
					tx_stalls++;
				end
			end
		end
		tx_valid = 1'b0;
		tx_last  = 1'b0;
	endtask

	// mode 0 good, 1 flipped payload bit, 2 rx_er mid frame, 3 bad delimiter
	task automatic drive_rx(bytes_t payload, int mode, bit deliver);
		bytes_t frame;
		frame = build_frame(payload);
		if (mode == 1) begin
			frame[8] = frame[8] ^ 8'h04;
		end
		if (mode == 3) begin
			frame[7] = 8'hD4;
		end
		if (deliver) begin
			foreach (payload[i]) begin
				rx_exp.push_back(payload[i]);
				rx_last_exp.push_back(i == payload.size() - 1);
			end
		end
		foreach (frame[i]) begin
			gmii_rxd   = frame[i];
			gmii_rx_dv = 1'b1;
			gmii_rx_er = (mode == 2 && i == 8 + payload.size() / 2);
			next_cycle();
		end
		gmii_rxd   = 8'h00;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		repeat (12) begin
			next_cycle();   // idle between frames
		end
	endtask

	task automatic wait_idle();
		while (tx_exp.size() != 0 || tx_len_exp.size() != 0 || rx_exp.size() != 0) begin
			next_cycle();
		end
	endtask

	// --------------------
	// clock, watchdog, rx_ready

	initial begin
		clock = 1'b0;
		forever begin
			#(CLOCK_NS / 2);
			clock = ~clock;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_error("timeout: the traffic did not finish within the watchdog limit");
	end

	initial begin
		logic [31:0] ready_state;
		int          mode_now;
		ready_state = 32'd3;
		rx_ready    = 1'b0;
		forever begin
			@(posedge clock);
			mode_now = ready_mode;   // mode as of this edge
			#10;
			if (mode_now == 2) begin
				ready_state = lfsr_next(ready_state);
				rx_ready    = ready_state[0];
			end else begin
				rx_ready = (mode_now == 1);
			end
		end
	end

	// --------------------
	// compare processes

	initial begin
		int         run;
		int         gap;
		int         exp_len;
		logic [7:0] exp_byte;
		run = 0;
		gap = 1000;   // no frame before the first
		forever begin
			@(negedge clock);
			if (gmii_tx_en) begin
				if (run == 0) begin
					assert (gap >= 12) else
						report_error($sformatf("gap before a frame was only %0d cycles", gap));
				end
				assert (tx_exp.size() > 0) else
					report_error("gmii_tx_en went high with no frame expected");
				exp_byte = tx_exp.pop_front();
				assert (gmii_txd === exp_byte) else
					report_error($sformatf("mismatch gmii_txd: got %h expected %h",
						gmii_txd, exp_byte));
				run++;
				gap = 0;
			end else begin
				if (run > 0) begin
					exp_len = tx_len_exp.pop_front();
					assert (run == exp_len) else
						report_error($sformatf("mismatch gmii_tx_en cycles: got %h expected %h",
							run, exp_len));
					run = 0;
				end
				gap++;
			end
		end
	end

	initial begin
		logic [7:0] exp_byte;
		logic       exp_last;
		forever begin
			@(negedge clock);
			if (rx_valid && rx_ready) begin
				assert (rx_exp.size() > 0) else
					report_error("rx stream delivered a byte that no good frame accounts for");
				exp_byte = rx_exp.pop_front();
				exp_last = rx_last_exp.pop_front();
				assert (rx_data === exp_byte) else
					report_error($sformatf("mismatch rx_data: got %h expected %h",
						rx_data, exp_byte));
				assert (rx_last === exp_last) else
					report_error($sformatf("mismatch rx_last: got %h expected %h",
						rx_last, exp_last));
			end
		end
	end

	// --------------------
	// test sequence

	initial begin
		reset      = 1'b1;
		tx_data    = 8'h00;
		tx_valid   = 1'b0;
		tx_last    = 1'b0;
		gmii_rxd   = 8'h00;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		lfsr_state = 32'd3;
		ready_mode = 1;
		tx_stalls  = 0;
		repeat (10) begin
			next_cycle();
		end
		assert (!tx_ready && !rx_valid && !gmii_tx_en) else
			report_error("outputs were not idle during reset");
		reset = 1'b0;
		next_cycle();

		// transmit framing with holes in tx_valid on two frames
		for (int k = 0; k < 3; k++) begin
			push_frame(random_payload(random_len()), k != 1);
		end
		wait_idle();

		// a long frame keeps the framer busy while short ones fill the ring
		tx_stalls = 0;
		push_frame(random_payload(200), 1'b0);
		for (int k = 0; k < 4; k++) begin
			push_frame(random_payload(random_len()), 1'b0);
		end
		assert (tx_stalls > 0) else
			report_error("tx_ready never fell while all transmit slots were in use");
		wait_idle();

		// good receive frames under random back pressure
		ready_mode = 2;
		for (int k = 0; k < 4; k++) begin
			drive_rx(random_payload(random_len()), 0, 1'b1);
		end
		wait_idle();
		ready_mode = 1;

		// bad crc, rx_er and broken delimiter, then one good frame
		for (int m = 1; m <= 3; m++) begin
			drive_rx(random_payload(random_len()), m, 1'b0);
		end
		drive_rx(random_payload(random_len()), 0, 1'b1);
		wait_idle();

		// the four receive slots fill up and the last two frames vanish
		ready_mode = 0;
		for (int k = 0; k < 6; k++) begin
			drive_rx(random_payload(random_len()), 0, k < 4);
		end
		ready_mode = 1;
		wait_idle();
		repeat (50) begin
			next_cycle();   // dropped frames must stay absent
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: compile.f
+incdir+dv
hw/eth_pkg.sv
hw/ring_wr_if.sv
hw/ring_rd_if.sv
hw/frame_ring.sv
hw/gmii_tx.sv
hw/gmii_rx.sv
hw/eth_mac.sv
dv/tb_eth_mac.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_eth_mac -f compile.f -o sim_tb_eth_mac &&
./obj_dir/sim_tb_eth_mac | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
